// File: common/core_pkg.sv
`default_nettype none

package core_pkg;

    // datapath widths
    localparam int addr_w = 32;
    localparam int data_w = 32;
    localparam int word_bytes = data_w / 8;

    // fixed axi read burst shape
    localparam int burst_len = 4;
    localparam int burst_bytes = burst_len * word_bytes;
    localparam int beat_w = $clog2(burst_len);

    // arlen is beats minus one
    localparam logic [7:0] axi_len_fixed = 8'(burst_len - 1);
    // 4 bytes per beat
    localparam logic [2:0] axi_size_word = 3'd2;
    localparam logic [1:0] axi_burst_incr = 2'd1;

    // fetch queue sizing
    localparam int queue_depth = 8;
    localparam int qptr_w = $clog2(queue_depth);

    // must hold the full queue_depth value, hence the +1
    localparam int credit_w = $clog2(queue_depth + 1);

    // boot vector, burst aligned
    localparam logic [addr_w-1:0] reset_pc = 32'h1fc0_0000;

    // architectural register file
    localparam int rf_depth = 32;
    localparam int reg_idx_w = $clog2(rf_depth);

    // primary opcodes, inst[31:26]
    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_addiu = 6'h09;
    localparam logic [5:0] op_ori = 6'h0d;
    localparam logic [5:0] op_lui = 6'h0f;

    // function field for special, inst[5:0]
    localparam logic [5:0] fn_addu = 6'h21;

    // write enable pattern for a full word write
    localparam logic [3:0] wen_word = 4'hf;

    // one fetched word plus the pc it came from
    typedef struct packed {
        logic [addr_w-1:0] pc;
        logic [data_w-1:0] inst;
    } fetch_entry_t;

endpackage

`default_nettype wire

// File: core_top.f
common/core_pkg.sv
fetch/fetch_axi_reader.sv
fetch/fetch_queue.sv
verilog/retire_trace.sv
verilog/core_top.sv
verif/core_top_tb.sv

// File: fetch/fetch_axi_reader.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_axi_reader
    import core_pkg::*;
(
    input  logic                aclk,
    input  logic                reset,
    // axi read address
    output logic [3:0]          arid,
    output logic [addr_w-1:0]   araddr,
    output logic [7:0]          arlen,
    output logic [2:0]          arsize,
    output logic [1:0]          arburst,
    output logic                arvalid,
    input  logic                arready,
    // axi read data
    input  logic [data_w-1:0]   rdata,
    input  logic                rlast,
    input  logic                rvalid,
    output logic                rready,
    // towards the fetch queue
    output logic                push_valid,
    output fetch_entry_t        push_entry,
    input  logic                credit_return
);

    logic [credit_w-1:0] credits;
    logic [credit_w-1:0] credits_next;
    logic [addr_w-1:0]   beat_pc;
    logic [beat_w-1:0]   beat_cnt;
    logic                ar_fire;
    logic                r_fire;

    assign ar_fire = arvalid && arready;
    assign r_fire = rvalid && rready;

    // single id, fixed burst shape
    assign arid = 4'd0;
    assign arlen = axi_len_fixed;
    assign arsize = axi_size_word;
    assign arburst = axi_burst_incr;

    // spend a burst worth on the AR handshake, get one back per pop
    always_comb begin
        credits_next = credits;
        if (ar_fire) begin
            credits_next = credits_next - credit_w'(burst_len);
        end
        if (credit_return) begin
            credits_next = credits_next + 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        if (reset) begin
            credits <= credit_w'(queue_depth);
        end else begin
            credits <= credits_next;
        end
    end

    // request only with room for a whole burst
    // address advances once the request is accepted
    always_ff @(posedge aclk) begin
        if (reset) begin
            arvalid <= 1'b0;
            araddr <= reset_pc;
        end else if (ar_fire) begin
            arvalid <= 1'b0;
            araddr <= araddr + addr_w'(burst_bytes);
        end else if (!arvalid && credits >= credit_w'(burst_len)) begin
            arvalid <= 1'b1;
        end
    end

    // space already reserved, so always ready after reset
    always_ff @(posedge aclk) begin
        if (reset) begin
            rready <= 1'b0;
        end else begin
            rready <= 1'b1;
        end
    end

    // bursts are contiguous and in order, so one running pc covers every beat
    always_ff @(posedge aclk) begin
        if (reset) begin
            beat_pc <= reset_pc;
            beat_cnt <= '0;
        end else if (r_fire) begin
            beat_pc <= beat_pc + addr_w'(word_bytes);
            beat_cnt <= rlast ? '0 : beat_cnt + 1'b1;
        end
    end

    // push one cycle after the beat
    always_ff @(posedge aclk) begin
        if (reset) begin
            push_valid <= 1'b0;
        end else begin
            push_valid <= r_fire;
        end
    end

    always_ff @(posedge aclk) begin
        if (r_fire) begin
            push_entry.pc <= beat_pc;
            push_entry.inst <= rdata;
        end
    end

    a_ar_hold: assert property (@(posedge aclk) disable iff (reset)
        arvalid && !arready |=> arvalid && $stable(araddr));

    // last beat exactly at the end of the fixed length burst
    a_rlast_pos: assert property (@(posedge aclk) disable iff (reset)
        r_fire |-> (rlast == (beat_cnt == beat_w'(burst_len - 1))));

    a_credit_max: assert property (@(posedge aclk) disable iff (reset)
        credits <= credit_w'(queue_depth));

endmodule

`default_nettype wire

// File: fetch/fetch_queue.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_queue
    import core_pkg::*;
(
    input  logic         aclk,
    input  logic         reset,
    input  logic         push_valid,
    input  fetch_entry_t push_entry,
    input  logic         pop,
    output logic         pop_valid,
    output fetch_entry_t pop_entry,
    output logic         credit_return
);

    fetch_entry_t        mem [queue_depth];
    logic [qptr_w-1:0]   wr_ptr;
    logic [qptr_w-1:0]   rd_ptr;
    logic [credit_w-1:0] count;
    logic                full;

    assign full = count == credit_w'(queue_depth);
    assign pop_valid = count != '0;
    // head entry visible straight from storage
    assign pop_entry = mem[rd_ptr];

    always_ff @(posedge aclk) begin
        if (push_valid) begin
            mem[wr_ptr] <= push_entry;
        end
    end

    // pointers wrap naturally, depth is a power of two
    always_ff @(posedge aclk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (reset) begin
            count <= '0;
        end else begin
            case ({push_valid, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // one credit back per freed slot
    always_ff @(posedge aclk) begin
        if (reset) begin
            credit_return <= 1'b0;
        end else begin
            credit_return <= pop;
        end
    end

    // the reader's credit count is what keeps this from firing
    a_no_overflow: assert property (@(posedge aclk) disable iff (reset)
        push_valid |-> !full);

    a_no_underflow: assert property (@(posedge aclk) disable iff (reset)
        pop |-> pop_valid);

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the core_top testbench with Verilator
# exit status is nonzero when the build or the simulation fails

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module core_top_tb \
    -f core_top.f \
    -o core_top_sim \
    && ./obj_dir/core_top_sim \
    && echo "simulation finished" \
    || { echo "simulation or build failed"; exit 1; }

// File: verif/core_top_tb.sv
`timescale 1ns/1ps
`default_nettype none

module core_top_tb
    import core_pkg::*;
();

    localparam int n_prog = 24;
    localparam int half_period = 20;
    localparam int reset_cycles = 16;
    localparam int drive_delay = 1;
    localparam int timeout_cycles = n_prog * 40 + 200;

    logic                 aclk;
    logic                 reset;
    logic [3:0]           arid;
    logic [addr_w-1:0]    araddr;
    logic [7:0]           arlen;
    logic [2:0]           arsize;
    logic [1:0]           arburst;
    logic                 arvalid;
    logic                 arready;
    logic [3:0]           rid;
    logic [data_w-1:0]    rdata;
    logic [1:0]           rresp;
    logic                 rlast;
    logic                 rvalid;
    logic                 rready;
    logic                 debug0_wb_valid;
    logic [addr_w-1:0]    debug0_wb_pc;
    logic [3:0]           debug0_wb_rf_wen;
    logic [reg_idx_w-1:0] debug0_wb_rf_wnum;
    logic [data_w-1:0]    debug0_wb_rf_wdata;
    logic [data_w-1:0]    debug0_wb_inst;

    // program and expected trace, one row per instruction
    logic [data_w-1:0]    prog [n_prog];
    logic [3:0]           exp_wen [n_prog];
    logic [reg_idx_w-1:0] exp_wnum [n_prog];
    logic [data_w-1:0]    exp_wdata [n_prog];
    // sparse memory, filled from the program table
    logic [data_w-1:0]    mem [logic [addr_w-1:0]];

    integer seed = 31773;
    int cycles = 0;
    int retired = 0;
    int bursts = 0;
    int beat = 0;
    logic ar_fire = 1'b0;
    logic r_fire = 1'b0;
    logic [addr_w-1:0] ar_addr_seen = '0;
    // accepted burst addresses, oldest first
    logic [addr_w-1:0] burst_q [$];

    core_top DUT (.*);

    always begin
        #(half_period);
        aclk = ~aclk;
    end

    task automatic abort_run(input string what);
        $display("%s at %0t", what, $time);
        $display("Test failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_word(input string name, input logic [data_w-1:0] got,
                              input logic [data_w-1:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            $display("Test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_wen(input string name, input logic [3:0] got, input logic [3:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            $display("Test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_wnum(input string name, input logic [reg_idx_w-1:0] got,
                              input logic [reg_idx_w-1:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
            $display("Test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // i-type: op rs rt imm
    function automatic logic [data_w-1:0] enc_i(input logic [5:0] op, input int rs, input int rt,
                                                input logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    // r-type under special
    function automatic logic [data_w-1:0] enc_r(input int rs, input int rt, input int rd,
                                                input logic [5:0] fn);
        return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
    endfunction

    task automatic load_program();
        prog[0] = enc_i(6'h0f, 0, 1, 16'h1234);
        prog[1] = enc_i(6'h0d, 1, 1, 16'h5678);
        prog[2] = enc_i(6'h09, 0, 2, 16'h7fff);
        // negative immediate
        prog[3] = enc_i(6'h09, 2, 3, 16'hffff);
        prog[4] = enc_r(1, 3, 4, 6'h21);
        // write to r0 dropped
        prog[5] = enc_i(6'h09, 1, 0, 16'h0005);
        // store opcode, not supported
        prog[6] = enc_i(6'h2b, 1, 2, 16'h0000);
        prog[7] = enc_i(6'h0f, 0, 5, 16'hffff);
        prog[8] = enc_i(6'h0d, 5, 5, 16'h8001);
        prog[9] = enc_r(5, 5, 6, 6'h21);
        prog[10] = enc_i(6'h09, 6, 7, 16'h8000);
        // and, a special that is not addu
        prog[11] = enc_r(1, 2, 8, 6'h24);
        prog[12] = enc_r(1, 2, 0, 6'h21);
        prog[13] = enc_i(6'h0d, 0, 8, 16'habcd);
        prog[14] = enc_r(8, 1, 9, 6'h21);
        prog[15] = enc_i(6'h0f, 0, 10, 16'h8000);
        // wraps to zero
        prog[16] = enc_r(10, 10, 10, 6'h21);
        prog[17] = enc_i(6'h09, 10, 11, 16'h0001);
        prog[18] = enc_r(11, 9, 12, 6'h21);
        prog[19] = enc_i(6'h0d, 12, 12, 16'h00ff);
        // branch opcode, not supported
        prog[20] = enc_i(6'h04, 1, 2, 16'h0010);
        prog[21] = enc_i(6'h09, 12, 13, 16'hfffe);
        prog[22] = enc_r(13, 7, 14, 6'h21);
        prog[23] = enc_i(6'h0f, 0, 31, 16'h0001);
        for (int i = 0; i < n_prog; i++) begin
            mem[reset_pc + addr_w'(i * 4)] = prog[i];
        end
    endtask

    // reference register model, walks the program in order
    task automatic compute_expected();
        logic [data_w-1:0] regs [32];
        logic [data_w-1:0] value;
        logic [15:0]       imm;
        logic [4:0]        dest;
        logic              wr;
        for (int r = 0; r < 32; r++) begin
            regs[r] = '0;
        end
        for (int i = 0; i < n_prog; i++) begin
            imm = prog[i][15:0];
            dest = prog[i][20:16];
            value = '0;
            wr = 1'b1;
            case (prog[i][31:26])
                6'h09: value = regs[prog[i][25:21]] + {{16{imm[15]}}, imm};
                6'h0d: value = regs[prog[i][25:21]] | {16'h0000, imm};
                6'h0f: value = {imm, 16'h0000};
                6'h00: begin
                    dest = prog[i][15:11];
                    value = regs[prog[i][25:21]] + regs[prog[i][20:16]];
                    wr = prog[i][5:0] == 6'h21;
                end
                default: wr = 1'b0;
            endcase
            if (dest == 5'd0) begin
                wr = 1'b0;
            end
            exp_wen[i] = wr ? 4'hf : 4'h0;
            exp_wnum[i] = dest;
            exp_wdata[i] = value;
            if (wr) begin
                regs[dest] = value;
            end
        end
    endtask

    function automatic logic [data_w-1:0] mem_word(input logic [addr_w-1:0] addr);
        if (mem.exists(addr)) begin
            return mem[addr];
        end
        return '0;
    endfunction

    always @(posedge aclk) begin
        cycles = cycles + 1;
        if (cycles >= timeout_cycles) begin
            abort_run("timeout before all instructions retired");
        end
    end

    // mid-cycle sampling, everything stable here
    always @(negedge aclk) begin
        ar_fire = arvalid && arready;
        r_fire = rvalid && rready;
        ar_addr_seen = araddr;
        // arvalid and rready settle after the registered reset has reached the reader
        if (reset && cycles >= 2 && arvalid !== 1'b0) begin
            abort_run("arvalid high during reset");
        end
        if (reset && cycles >= 2 && rready !== 1'b0) begin
            abort_run("rready high during reset");
        end
        // reader ready two cycles after the external reset drops
        if (!reset && cycles >= reset_cycles + 2 && rready !== 1'b1) begin
            abort_run("rready low after reset");
        end
        if (!reset && debug0_wb_valid === 1'b1 && retired < n_prog) begin
            check_word("debug0_wb_pc", debug0_wb_pc, reset_pc + addr_w'(retired * 4));
            check_word("debug0_wb_inst", debug0_wb_inst, prog[retired]);
            check_wen("debug0_wb_rf_wen", debug0_wb_rf_wen, exp_wen[retired]);
            // number and data only mean something for a real write
            if (exp_wen[retired] != 4'h0) begin
                check_wnum("debug0_wb_rf_wnum", debug0_wb_rf_wnum, exp_wnum[retired]);
                check_word("debug0_wb_rf_wdata", debug0_wb_rf_wdata, exp_wdata[retired]);
            end
            retired = retired + 1;
        end
        if (ar_fire) begin
            check_word("araddr", araddr, reset_pc + addr_w'(bursts * 16));
            check_word("arid", {28'h0, arid}, 32'd0);
            check_word("arlen", {24'h0, arlen}, 32'd3);
            check_word("arsize", {29'h0, arsize}, 32'd2);
            check_word("arburst", {30'h0, arburst}, 32'd1);
            bursts = bursts + 1;
            // at most two bursts ahead of retirement
            if (bursts * 4 - retired > 8) begin
                abort_run("more than two bursts outstanding");
            end
        end
    end

    // axi read memory model, acts on the handshakes seen before the edge
    always @(posedge aclk) begin
        #(drive_delay);
        if (ar_fire) begin
            burst_q.push_back(ar_addr_seen);
        end
        if (r_fire) begin
            if (beat == 3) begin
                beat = 0;
                void'(burst_q.pop_front());
            end else begin
                beat = beat + 1;
            end
        end
        // ready about three cycles in four
        arready = ($random(seed) & 3) != 0;
        // an offered beat stays until taken
        if (!(rvalid && !r_fire)) begin
            if (burst_q.size() > 0 && ($random(seed) & 1) == 1) begin
                rvalid = 1'b1;
                rdata = mem_word(burst_q[0] + addr_w'(beat * 4));
                rlast = beat == 3;
            end else begin
                rvalid = 1'b0;
                rlast = 1'b0;
            end
        end
    end

    initial begin
        aclk = 1'b0;
        reset = 1'b1;
        arready = 1'b0;
        rid = 4'd0;
        rdata = '0;
        rresp = 2'b00;
        rlast = 1'b0;
        rvalid = 1'b0;
        load_program();
        compute_expected();
        repeat (reset_cycles) @(posedge aclk);
        #(drive_delay);
        reset = 1'b0;
        wait (retired == n_prog);
        @(posedge aclk);
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/core_top.sv
`timescale 1ns/1ps
`default_nettype none

module core_top
    import core_pkg::*;
(
    input  logic                 aclk,
    input  logic                 reset,
    // read request
    output logic [3:0]           arid,
    output logic [addr_w-1:0]    araddr,
    output logic [7:0]           arlen,
    output logic [2:0]           arsize,
    output logic [1:0]           arburst,
    output logic                 arvalid,
    input  logic                 arready,
    // read data
    input  logic [3:0]           rid,
    input  logic [data_w-1:0]    rdata,
    input  logic [1:0]           rresp,
    input  logic                 rlast,
    input  logic                 rvalid,
    output logic                 rready,
    // retire trace
    output logic                 debug0_wb_valid,
    output logic [addr_w-1:0]    debug0_wb_pc,
    output logic [3:0]           debug0_wb_rf_wen,
    output logic [reg_idx_w-1:0] debug0_wb_rf_wnum,
    output logic [data_w-1:0]    debug0_wb_rf_wdata,
    output logic [data_w-1:0]    debug0_wb_inst
);

    logic         core_reset;
    logic         push_valid;
    fetch_entry_t push_entry;
    logic         credit_return;
    logic         pop_valid;
    fetch_entry_t pop_entry;
    logic         pop;

    // external reset registered once, whole core sees it a cycle late
    always_ff @(posedge aclk) begin
        core_reset <= reset;
    end

    fetch_axi_reader u_reader (
        .aclk          (aclk),
        .reset         (core_reset),
        .arid          (arid),
        .araddr        (araddr),
        .arlen         (arlen),
        .arsize        (arsize),
        .arburst       (arburst),
        .arvalid       (arvalid),
        .arready       (arready),
        .rdata         (rdata),
        .rlast         (rlast),
        .rvalid        (rvalid),
        .rready        (rready),
        .push_valid    (push_valid),
        .push_entry    (push_entry),
        .credit_return (credit_return)
    );

    fetch_queue u_queue (
        .aclk          (aclk),
        .reset         (core_reset),
        .push_valid    (push_valid),
        .push_entry    (push_entry),
        .pop           (pop),
        .pop_valid     (pop_valid),
        .pop_entry     (pop_entry),
        .credit_return (credit_return)
    );

    retire_trace u_retire (
        .aclk               (aclk),
        .reset              (core_reset),
        .pop_valid          (pop_valid),
        .pop_entry          (pop_entry),
        .pop                (pop),
        .debug0_wb_valid    (debug0_wb_valid),
        .debug0_wb_pc       (debug0_wb_pc),
        .debug0_wb_rf_wen   (debug0_wb_rf_wen),
        .debug0_wb_rf_wnum  (debug0_wb_rf_wnum),
        .debug0_wb_rf_wdata (debug0_wb_rf_wdata),
        .debug0_wb_inst     (debug0_wb_inst)
    );

    // returned data must carry our only id and an OKAY response
    a_r_resp: assert property (@(posedge aclk) disable iff (core_reset)
        rvalid && rready |-> rid == arid && rresp == 2'b00);

endmodule

`default_nettype wire

// File: verilog/retire_trace.sv
`timescale 1ns/1ps
`default_nettype none

module retire_trace
    import core_pkg::*;
(
    input  logic                 aclk,
    input  logic                 reset,
    input  logic                 pop_valid,
    input  fetch_entry_t         pop_entry,
    output logic                 pop,
    // write-back trace
    output logic                 debug0_wb_valid,
    output logic [addr_w-1:0]    debug0_wb_pc,
    output logic [3:0]           debug0_wb_rf_wen,
    output logic [reg_idx_w-1:0] debug0_wb_rf_wnum,
    output logic [data_w-1:0]    debug0_wb_rf_wdata,
    output logic [data_w-1:0]    debug0_wb_inst
);

    logic [data_w-1:0]    rf [rf_depth];
    logic [5:0]           opcode;
    logic [5:0]           funct;
    logic [reg_idx_w-1:0] rs;
    logic [reg_idx_w-1:0] rt;
    logic [reg_idx_w-1:0] rd;
    logic [15:0]          imm;
    logic [data_w-1:0]    rs_val;
    logic [data_w-1:0]    rt_val;
    logic [reg_idx_w-1:0] dst;
    logic [data_w-1:0]    result;
    logic                 writes;
    logic                 do_write;

    // never stalls, take whatever is at the head
    assign pop = pop_valid;

    // field split
    assign opcode = pop_entry.inst[31:26];
    assign rs = pop_entry.inst[25:21];
    assign rt = pop_entry.inst[20:16];
    assign rd = pop_entry.inst[15:11];
    assign imm = pop_entry.inst[15:0];
    assign funct = pop_entry.inst[5:0];

    assign rs_val = rf[rs];
    assign rt_val = rf[rt];

    always_comb begin
        writes = 1'b0;
        dst = '0;
        result = '0;
        case (opcode)
            op_addiu: begin
                writes = 1'b1;
                dst = rt;
                result = rs_val + {{16{imm[15]}}, imm};
            end
            op_ori: begin
                writes = 1'b1;
                dst = rt;
                result = rs_val | {16'h0000, imm};
            end
            op_lui: begin
                writes = 1'b1;
                dst = rt;
                result = {imm, 16'h0000};
            end
            op_special: begin
                // only addu among the special group
                if (funct == fn_addu) begin
                    writes = 1'b1;
                    dst = rd;
                    result = rs_val + rt_val;
                end
            end
            default: begin
                writes = 1'b0;
            end
        endcase
    end

    // r0 stays zero, write dropped
    assign do_write = pop && writes && (dst != '0);

    // one retirement per cycle, next read sees this write
    always_ff @(posedge aclk) begin
        if (reset) begin
            for (int i = 0; i < rf_depth; i++) begin
                rf[i] <= '0;
            end
        end else if (do_write) begin
            rf[dst] <= result;
        end
    end

    always_ff @(posedge aclk) begin
        if (reset) begin
            debug0_wb_valid <= 1'b0;
            debug0_wb_rf_wen <= 4'h0;
        end else begin
            debug0_wb_valid <= pop;
            debug0_wb_rf_wen <= do_write ? wen_word : 4'h0;
        end
    end

    // trace payload
    always_ff @(posedge aclk) begin
        if (pop) begin
            debug0_wb_pc <= pop_entry.pc;
            debug0_wb_inst <= pop_entry.inst;
            debug0_wb_rf_wnum <= dst;
            debug0_wb_rf_wdata <= result;
        end
    end

endmodule

`default_nettype wire
